/* hdl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // Primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;

    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;

    // REGIMM selects on the rt field
    localparam reg_addr_t RI_BLTZ   = 5'h00;
    localparam reg_addr_t RI_BGEZ   = 5'h01;
    localparam reg_addr_t RI_BLTZAL = 5'h10;
    localparam reg_addr_t RI_BGEZAL = 5'h11;

    localparam reg_addr_t LINK_REG = 5'd31;  // $ra

    localparam word_t MIPS_RESET_PC = 32'hBFC0_0000;  // Boot ROM base

endpackage

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire mips_pkg::reg_addr_t rs_addr,
    input  wire mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::word_t          rs_value,
    output mips_pkg::word_t          rt_value,
    input  wire                      we,
    input  wire mips_pkg::reg_addr_t wa,
    input  wire mips_pkg::word_t     wd
);

    mips_pkg::word_t regs [1:31];  // $zero has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous reads so a write lands for the next cycle
    assign rs_value = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
    assign rt_value = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

    assert property (@(posedge clk) disable iff (!rst_n) we |-> !$isunknown(wa))
        else $error("register write with unknown address");

endmodule

`default_nettype wire

/* hdl/branch_resolve.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_resolve (
    input  wire mips_pkg::word_t inst,
    input  wire mips_pkg::word_t pc,
    input  wire mips_pkg::word_t rs_value,
    input  wire mips_pkg::word_t rt_value,
    output logic                 is_branch,
    output mips_pkg::word_t      branch_address,
    output mips_pkg::word_t      return_address,
    output logic                 is_link,
    output mips_pkg::reg_addr_t  link_dest
);

    mips_pkg::opcode_t   opcode;
    mips_pkg::funct_t    funct;
    mips_pkg::reg_addr_t rt_field;
    mips_pkg::reg_addr_t rd_field;
    mips_pkg::word_t     ds_addr;
    mips_pkg::word_t     offset_target;
    mips_pkg::word_t     jump_target;
    logic                rs_neg;
    logic                rs_zero;

    assign opcode   = inst[31:26];
    assign funct    = inst[5:0];
    assign rt_field = inst[20:16];
    assign rd_field = inst[15:11];

    assign ds_addr        = pc + 32'd4;  // Delay slot
    assign offset_target  = ds_addr + {{14{inst[15]}}, inst[15:0], 2'b00};
    assign jump_target    = {ds_addr[31:28], inst[25:0], 2'b00};  // Same 256 MB region
    assign return_address = pc + 32'd8;  // Skips the slot

    assign rs_neg  = rs_value[31];
    assign rs_zero = (rs_value == 32'd0);

    always_comb begin
        is_branch      = 1'b0;
        branch_address = 32'd0;
        is_link        = 1'b0;
        link_dest      = mips_pkg::LINK_REG;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                if (funct == mips_pkg::FN_JR || funct == mips_pkg::FN_JALR) begin
                    is_branch      = 1'b1;
                    branch_address = rs_value;
                end
                if (funct == mips_pkg::FN_JALR) begin
                    is_link   = 1'b1;
                    link_dest = rd_field;
                end
            end
            mips_pkg::OP_REGIMM: begin
                case (rt_field)
                    mips_pkg::RI_BLTZ, mips_pkg::RI_BLTZAL: begin
                        is_branch = rs_neg;
                    end
                    mips_pkg::RI_BGEZ, mips_pkg::RI_BGEZAL: begin
                        is_branch = !rs_neg;
                    end
                    default: ;
                endcase
                if (is_branch) branch_address = offset_target;
                // Link is written even when not taken
                is_link = (rt_field == mips_pkg::RI_BLTZAL) ||
                          (rt_field == mips_pkg::RI_BGEZAL);
            end
            mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                is_branch      = 1'b1;
                branch_address = jump_target;
                is_link        = (opcode == mips_pkg::OP_JAL);
            end
            mips_pkg::OP_BEQ:  is_branch = (rs_value == rt_value);
            mips_pkg::OP_BNE:  is_branch = (rs_value != rt_value);
            mips_pkg::OP_BLEZ: is_branch = rs_neg || rs_zero;
            mips_pkg::OP_BGTZ: is_branch = !rs_neg && !rs_zero;
            default: ;
        endcase
        if (is_branch && opcode >= mips_pkg::OP_BEQ && opcode <= mips_pkg::OP_BGTZ) begin
            branch_address = offset_target;
        end
    end

endmodule

`default_nettype wire

/* hdl/pc_control.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_control #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::MIPS_RESET_PC
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      inst_valid,
    input  wire                      stall,
    input  wire mips_pkg::word_t     inst,
    input  wire                      is_branch,
    input  wire mips_pkg::word_t     branch_address,
    input  wire mips_pkg::word_t     return_address,
    input  wire                      is_link,
    input  wire mips_pkg::reg_addr_t link_dest,
    input  wire                      wb_en,
    input  wire mips_pkg::reg_addr_t wb_addr,
    input  wire mips_pkg::word_t     wb_data,
    output mips_pkg::word_t          pc,
    output mips_pkg::reg_addr_t      rs_addr,
    output mips_pkg::reg_addr_t      rt_addr,
    output logic                     rf_we,
    output mips_pkg::reg_addr_t      rf_wa,
    output mips_pkg::word_t          rf_wd,
    output logic                     branch_taken,
    output logic                     link_en
);

    typedef enum logic {
        ST_BOOT,
        ST_RUN
    } pc_state_t;

    pc_state_t       state;
    logic            accept;
    logic            in_slot;         // Current pc is a delay slot
    mips_pkg::word_t pending_target;

    assign rs_addr = inst[25:21];
    assign rt_addr = inst[20:16];

    assign accept = inst_valid && !stall && (state == ST_RUN);

    // A branch sitting in a delay slot does not redirect
    assign branch_taken = accept && is_branch && !in_slot;
    assign link_en      = accept && is_link;

    // Link write wins over writeback
    assign rf_we = link_en || wb_en;
    assign rf_wa = link_en ? link_dest : wb_addr;
    assign rf_wd = link_en ? return_address : wb_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_BOOT;
            pc      <= RESET_PC;
            in_slot <= 1'b0;
        end else begin
            case (state)
                ST_BOOT: state <= ST_RUN;
                ST_RUN: begin
                    if (accept) begin
                        pc      <= in_slot ? pending_target : pc + 32'd4;
                        in_slot <= branch_taken;
                    end
                end
                default: state <= ST_BOOT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (branch_taken) pending_target <= branch_address;
    end

    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc misaligned: %h", pc);

    assert property (@(posedge clk) disable iff (!rst_n) (stall || !inst_valid) |=> $stable(pc))
        else $error("pc moved while stage was held");

endmodule

`default_nettype wire

/* hdl/branch_stage_top.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_stage_top #(
    parameter mips_pkg::word_t RESET_PC = mips_pkg::MIPS_RESET_PC
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      inst_valid,
    input  wire mips_pkg::word_t     inst,
    input  wire                      stall,
    input  wire                      wb_en,
    input  wire mips_pkg::reg_addr_t wb_addr,
    input  wire mips_pkg::word_t     wb_data,
    output wire mips_pkg::word_t     pc,
    output wire                      branch_taken,
    output wire mips_pkg::word_t     branch_target,
    output wire                      link_en,
    output wire mips_pkg::reg_addr_t link_addr,
    output wire mips_pkg::word_t     link_data
);

    wire mips_pkg::reg_addr_t rs_addr;
    wire mips_pkg::reg_addr_t rt_addr;
    wire mips_pkg::word_t     rs_value;
    wire mips_pkg::word_t     rt_value;
    wire                      is_branch;
    wire mips_pkg::word_t     branch_address;
    wire mips_pkg::word_t     return_address;
    wire                      is_link;
    wire mips_pkg::reg_addr_t link_dest;
    wire                      rf_we;
    wire mips_pkg::reg_addr_t rf_wa;
    wire mips_pkg::word_t     rf_wd;

    pc_control #(.RESET_PC(RESET_PC)) ctrl_i (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .stall(stall), .inst(inst),
        .is_branch(is_branch), .branch_address(branch_address),
        .return_address(return_address), .is_link(is_link), .link_dest(link_dest),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .pc(pc),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rf_we(rf_we), .rf_wa(rf_wa), .rf_wd(rf_wd),
        .branch_taken(branch_taken), .link_en(link_en)
    );

    reg_file rf_i (
        .clk(clk), .rst_n(rst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .rs_value(rs_value), .rt_value(rt_value), .we(rf_we), .wa(rf_wa), .wd(rf_wd)
    );

    branch_resolve br_i (
        .inst(inst), .pc(pc), .rs_value(rs_value), .rt_value(rt_value),
        .is_branch(is_branch), .branch_address(branch_address),
        .return_address(return_address), .is_link(is_link), .link_dest(link_dest)
    );

    assign branch_target = branch_address;
    assign link_addr     = rf_wa;  // Valid while link_en
    assign link_data     = rf_wd;

endmodule

`default_nettype wire

/* bench/branch_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_stage_tb;

    localparam mips_pkg::word_t TB_RESET_PC = 32'h0040_0000;
    localparam int MAX_ROWS = 48;

    logic                clk;
    logic                rst_n;
    logic                inst_valid;
    mips_pkg::word_t     inst;
    logic                stall;
    logic                wb_en;
    mips_pkg::reg_addr_t wb_addr;
    mips_pkg::word_t     wb_data;
    wire mips_pkg::word_t     pc;
    wire                      branch_taken;
    wire mips_pkg::word_t     branch_target;
    wire                      link_en;
    wire mips_pkg::reg_addr_t link_addr;
    wire mips_pkg::word_t     link_data;

    // Stimulus and expected values, one row per cycle
    mips_pkg::word_t     row_inst   [MAX_ROWS];
    logic                row_valid  [MAX_ROWS];
    logic                row_stall  [MAX_ROWS];
    logic                row_taken  [MAX_ROWS];
    mips_pkg::word_t     row_target [MAX_ROWS];
    logic                row_link   [MAX_ROWS];
    mips_pkg::reg_addr_t row_dest   [MAX_ROWS];
    mips_pkg::word_t     row_ldata  [MAX_ROWS];
    mips_pkg::word_t     row_pc     [MAX_ROWS];  // pc after the step

    int              num_rows = 0;
    int              cur_row = -1;
    integer          seed = 87591;
    logic            table_ready = 1'b0;
    mips_pkg::word_t expected_pc;

    branch_stage_top #(.RESET_PC(TB_RESET_PC)) dut_i (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst), .stall(stall),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .pc(pc),
        .branch_taken(branch_taken), .branch_target(branch_target), .link_en(link_en),
        .link_addr(link_addr), .link_data(link_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic mips_pkg::word_t enc_i(input mips_pkg::opcode_t op,
                                              input mips_pkg::reg_addr_t rs,
                                              input mips_pkg::reg_addr_t rt,
                                              input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_pkg::word_t enc_j(input mips_pkg::opcode_t op,
                                              input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic mips_pkg::word_t enc_r(input mips_pkg::reg_addr_t rs,
                                              input mips_pkg::reg_addr_t rd,
                                              input mips_pkg::funct_t fn);
        return {mips_pkg::OP_SPECIAL, rs, 5'd0, rd, 5'd0, fn};
    endfunction

    task automatic fail_now();
        $display("test failed");
        $fatal(1, "check failed in row %0d", cur_row);
    endtask

    task automatic check_word(input string name, input mips_pkg::word_t exp,
                              input mips_pkg::word_t act);
        if (act !== exp) begin
            $display("Fail %s (row %0d): expected %h, got %h", name, cur_row, exp, act);
            fail_now();
        end
    endtask

    task automatic check_reg(input string name, input mips_pkg::reg_addr_t exp,
                             input mips_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("Fail %s (row %0d): expected %h, got %h", name, cur_row, exp, act);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s (row %0d): expected %h, got %h", name, cur_row, exp, act);
            fail_now();
        end
    endtask

    task automatic add_row(input mips_pkg::word_t i, input logic v, input logic s,
                           input logic t, input mips_pkg::word_t tgt, input logic l,
                           input mips_pkg::reg_addr_t d, input mips_pkg::word_t ld,
                           input mips_pkg::word_t pc_after);
        row_inst[num_rows]   = i;
        row_valid[num_rows]  = v;
        row_stall[num_rows]  = s;
        row_taken[num_rows]  = t;
        row_target[num_rows] = tgt;
        row_link[num_rows]   = l;
        row_dest[num_rows]   = d;
        row_ldata[num_rows]  = ld;
        row_pc[num_rows]     = pc_after;
        num_rows++;
    endtask

    task automatic add_plain(input mips_pkg::word_t i, input mips_pkg::word_t pc_after);
        add_row(i, 1'b1, 1'b0, 1'b0, 32'd0, 1'b0, 5'd0, 32'd0, pc_after);
    endtask

    task automatic add_taken(input mips_pkg::word_t i, input mips_pkg::word_t tgt,
                             input mips_pkg::word_t pc_after);
        add_row(i, 1'b1, 1'b0, 1'b1, tgt, 1'b0, 5'd0, 32'd0, pc_after);
    endtask

    task automatic add_link(input mips_pkg::word_t i, input logic t, input mips_pkg::word_t tgt,
                            input mips_pkg::reg_addr_t d, input mips_pkg::word_t ld,
                            input mips_pkg::word_t pc_after);
        add_row(i, 1'b1, 1'b0, t, tgt, 1'b1, d, ld, pc_after);
    endtask

    // Stalled or invalid cycle, nothing may happen
    task automatic add_hold(input mips_pkg::word_t i, input logic v, input logic s,
                            input mips_pkg::word_t pc_after);
        add_row(i, v, s, 1'b0, 32'd0, 1'b0, 5'd0, 32'd0, pc_after);
    endtask

    task automatic add_filler(input mips_pkg::word_t pc_after);
        mips_pkg::word_t r;
        r = $random(seed);
        add_plain({3'b001, r[28:0]}, pc_after);  // Opcodes 0x08..0x0F, ALU immediates
    endtask

    task automatic build_table();
        add_taken(enc_i(mips_pkg::OP_BEQ, 5'd4, 5'd5, 16'h0004), 32'h0040_0014, 32'h0040_0004);
        add_filler(32'h0040_0014);
        add_plain(enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'h0008), 32'h0040_0018);
        add_taken(enc_i(mips_pkg::OP_BNE, 5'd1, 5'd2, 16'hFFFC), 32'h0040_000C, 32'h0040_001C);
        add_filler(32'h0040_000C);
        add_plain(enc_i(mips_pkg::OP_BNE, 5'd4, 5'd5, 16'h0003), 32'h0040_0010);
        add_taken(enc_i(mips_pkg::OP_BLEZ, 5'd3, 5'd0, 16'h0010), 32'h0040_0054, 32'h0040_0014);
        add_filler(32'h0040_0054);
        add_plain(enc_i(mips_pkg::OP_BLEZ, 5'd1, 5'd0, 16'h0010), 32'h0040_0058);
        add_taken(enc_i(mips_pkg::OP_BLEZ, 5'd2, 5'd0, 16'h0002), 32'h0040_0064, 32'h0040_005C);
        add_filler(32'h0040_0064);
        add_taken(enc_i(mips_pkg::OP_BGTZ, 5'd1, 5'd0, 16'hFFF8), 32'h0040_0048, 32'h0040_0068);
        add_hold(enc_j(mips_pkg::OP_JAL, 26'h10_00C0), 1'b1, 1'b1, 32'h0040_0068);
        add_filler(32'h0040_0048);
        add_plain(enc_i(mips_pkg::OP_BGTZ, 5'd3, 5'd0, 16'h0004), 32'h0040_004C);
        add_plain(enc_i(mips_pkg::OP_BGTZ, 5'd2, 5'd0, 16'h0004), 32'h0040_0050);
        add_taken(enc_i(mips_pkg::OP_REGIMM, 5'd2, mips_pkg::RI_BLTZ, 16'h0001),
                  32'h0040_0058, 32'h0040_0054);
        add_hold(enc_i(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RI_BGEZAL, 16'h0001),
                 1'b0, 1'b0, 32'h0040_0054);
        add_filler(32'h0040_0058);
        add_plain(enc_i(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RI_BLTZ, 16'h0004), 32'h0040_005C);
        add_taken(enc_i(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RI_BGEZ, 16'h0004),
                  32'h0040_0070, 32'h0040_0060);
        add_filler(32'h0040_0070);
        add_plain(enc_i(mips_pkg::OP_REGIMM, 5'd2, mips_pkg::RI_BGEZ, 16'h0004), 32'h0040_0074);
        add_taken(enc_j(mips_pkg::OP_J, 26'h10_0080), 32'h0040_0200, 32'h0040_0078);
        add_filler(32'h0040_0200);
        add_link(enc_j(mips_pkg::OP_JAL, 26'h10_00C0), 1'b1, 32'h0040_0300,
                 5'd31, 32'h0040_0208, 32'h0040_0204);
        add_filler(32'h0040_0300);
        add_taken(enc_r(5'd31, 5'd0, mips_pkg::FN_JR), 32'h0040_0208, 32'h0040_0304);
        add_filler(32'h0040_0208);
        add_link(enc_i(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RI_BGEZAL, 16'h0006), 1'b1,
                 32'h0040_0224, 5'd31, 32'h0040_0210, 32'h0040_020C);
        add_filler(32'h0040_0224);
        add_link(enc_i(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RI_BLTZAL, 16'h0006), 1'b0,
                 32'd0, 5'd31, 32'h0040_022C, 32'h0040_0228);
        add_taken(enc_r(5'd31, 5'd0, mips_pkg::FN_JR), 32'h0040_022C, 32'h0040_022C);
        add_filler(32'h0040_022C);  // Slot whose target is its own address
        add_link(enc_r(5'd7, 5'd8, mips_pkg::FN_JALR), 1'b1, 32'h0040_0300,
                 5'd8, 32'h0040_0234, 32'h0040_0230);
        add_filler(32'h0040_0300);
        add_taken(enc_r(5'd8, 5'd0, mips_pkg::FN_JR), 32'h0040_0234, 32'h0040_0304);
        add_filler(32'h0040_0234);
    endtask

    task automatic write_reg(input mips_pkg::reg_addr_t a, input mips_pkg::word_t d);
        @(posedge clk);
        wb_en   <= 1'b1;
        wb_addr <= a;
        wb_data <= d;
    endtask

    initial begin
        wait (table_ready);
        repeat (num_rows * 20 + 16 + 16) @(posedge clk);
        $display("Watchdog expired before the instruction table finished");
        $display("test failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = 32'd0;
        stall      = 1'b0;
        wb_en      = 1'b0;
        wb_addr    = 5'd0;
        wb_data    = 32'd0;
        build_table();
        table_ready = 1'b1;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("pc", TB_RESET_PC, pc);

        write_reg(5'd1, 32'h0000_0010);  // Positive
        write_reg(5'd2, 32'hFFFF_FFF0);  // Negative
        write_reg(5'd3, 32'h0000_0000);
        write_reg(5'd4, 32'h1234_5678);
        write_reg(5'd5, 32'h1234_5678);
        write_reg(5'd7, 32'h0040_0300);  // JALR target
        @(posedge clk);
        wb_en <= 1'b0;

        expected_pc = TB_RESET_PC;
        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            inst       <= row_inst[r];
            inst_valid <= row_valid[r];
            stall      <= row_stall[r];
            @(negedge clk);
            cur_row = r;
            check_word("pc", expected_pc, pc);
            check_bit("branch_taken", row_taken[r], branch_taken);
            if (row_taken[r]) begin
                check_word("branch_target", row_target[r], branch_target);
            end
            check_bit("link_en", row_link[r], link_en);
            if (row_link[r]) begin
                check_reg("link_addr", row_dest[r], link_addr);
                check_word("link_data", row_ldata[r], link_data);
            end
            expected_pc = row_pc[r];
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        check_word("pc", expected_pc, pc);  // Last row's step

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/mips_pkg.sv
hdl/reg_file.sv
hdl/branch_resolve.sv
hdl/pc_control.sv
hdl/branch_stage_top.sv
bench/branch_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the branch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module branch_stage_tb \
    -f filelist.f \
    -o sim_branch_stage

./obj_dir/sim_branch_stage
